//--- compile.f
+incdir+.
mem_pkg.sv
dmem_if.sv
stall_dmem.sv
dest_decode.sv
mem_stage.sv
mem_top.sv
tb_clk_gen.sv
tb_mem_top.sv

//--- Makefile
# Verilator build and run of the memory stage testbench
# override any variable on the command line, e.g. make run TOP=...

VERILATOR ?= verilator
TOP       ?= tb_mem_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) mem_stage_config.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, the header or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the binary is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_mem_top.sv
//////////////////////////////////////////////////////////////////////
// directed testbench of the memory stage subsystem
// each test drives mem_top one instruction at a time, waits for the
// stall to drop and checks the registered outputs against the inputs
// and a reference copy of the data memory
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_config.svh"

module tb_mem_top;

   localparam int NUM_TESTS    = 6;
   localparam int CLK_PERIOD   = 8;
   localparam int ACCESS_STALL = `DMEM_LATENCY - 1;

   logic        clk;
   logic        rst_n;
   logic [15:0] instr;
   logic [15:0] pc_inc;
   logic [15:0] b_in;
   logic [15:0] alu_res;
   logic [15:0] rt_data;
   logic        reg_wr;
   logic        align_err;
   logic [15:0] instr_out;
   logic [15:0] pc_inc_out;
   logic [15:0] b_out;
   logic [15:0] alu_out;
   logic [15:0] rdata_out;
   logic        reg_wr_out;
   logic        err_out;
   logic [2:0]  xm_rd;
   logic        mem_stall;

   // reference contents, indexed by byte address bits 8..1
   logic [15:0] model_mem [`DMEM_WORDS];
   logic [15:0] last_addr;

   tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(16)) i_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   mem_top i_dut (
      .clk(clk), .rst_n(rst_n), .instr(instr), .pc_inc(pc_inc), .b_in(b_in),
      .alu_res(alu_res), .rt_data(rt_data), .reg_wr(reg_wr), .align_err(align_err),
      .instr_out(instr_out), .pc_inc_out(pc_inc_out), .b_out(b_out), .alu_out(alu_out),
      .rdata_out(rdata_out), .reg_wr_out(reg_wr_out), .err_out(err_out),
      .xm_rd(xm_rd), .mem_stall(mem_stall)
   );

   task automatic stop_failed(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_eq(input string test, input string what,
                           input logic [15:0] exp, input logic [15:0] act);
      assert (act === exp) else begin
         stop_failed($sformatf("FAIL %s %s: expected %h, actual %h", test, what, exp, act));
      end
   endtask

   // whole pipeline register set as one word
   function automatic logic [81:0] held_outputs();
      return {instr_out, pc_inc_out, b_out, alu_out, rdata_out, reg_wr_out, err_out};
   endfunction

   // even byte address somewhere inside the memory
   function automatic logic [15:0] even_addr();
      return {7'd0, 8'($urandom), 1'b0};
   endfunction

   task automatic drive(input logic [15:0] ins, input logic [15:0] addr,
                        input logic [15:0] data, input logic wr_en, input logic aerr);
      instr     = ins;
      pc_inc    = 16'($urandom);
      b_in      = 16'($urandom);
      alu_res   = addr;
      rt_data   = data;
      reg_wr    = wr_en;
      align_err = aerr;
   endtask

   // wait out the current instruction, then check what was loaded
   task automatic finish_access(input string test);
      logic [81:0] held;
      logic        is_wr;
      logic        is_mem;
      int          stalls;
      held   = held_outputs();
      // st and stu write, ld reads
      is_wr  = (instr[15:11] == 5'b10000) || (instr[15:11] == 5'b10011);
      is_mem = is_wr || (instr[15:11] == 5'b10001);
      stalls = 0;
      // registers hold from the request up to the edge after done
      do begin
         @(negedge clk);
         assert (held_outputs() === held) else begin
            stop_failed($sformatf("FAIL %s freeze: expected %h, actual %h",
                                  test, held, held_outputs()));
         end
         if (mem_stall) stalls++;
      end while (mem_stall);
      @(posedge clk);
      #1;
      check_eq(test, "stall cycles", is_mem ? 16'(ACCESS_STALL) : 16'd0, 16'(stalls));
      check_eq(test, "instr_out", instr, instr_out);
      check_eq(test, "pc_inc_out", pc_inc, pc_inc_out);
      check_eq(test, "b_out", b_in, b_out);
      check_eq(test, "alu_out", alu_res, alu_out);
      check_eq(test, "reg_wr_out", 16'(reg_wr), 16'(reg_wr_out));
      // odd address only counts for a memory access
      check_eq(test, "err_out", 16'(align_err | (is_mem & alu_res[0])), 16'(err_out));
      if ((instr[15:11] == 5'b10001) && !alu_res[0]) begin
         check_eq(test, "rdata_out", model_mem[alu_res[8:1]], rdata_out);
      end
      if (is_wr && !alu_res[0]) begin
         model_mem[alu_res[8:1]] = rt_data;
      end
   endtask

   task automatic access(input string test, input logic [15:0] ins, input logic [15:0] addr,
                         input logic [15:0] data, input logic wr_en, input logic aerr);
      drive(ins, addr, data, wr_en, aerr);
      finish_access(test);
   endtask

   //////////////////////////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic reset_check();
      assert ((held_outputs() === '0) && (mem_stall === 1'b0)) else begin
         stop_failed($sformatf("FAIL reset_check outputs: expected 0, actual %h",
                               {held_outputs(), mem_stall}));
      end
   endtask

   task automatic passthrough();
      repeat (3) begin
         access("passthrough", {5'b01000, 11'($urandom)}, 16'($urandom),
                16'($urandom), 1'($urandom), 1'b0);
      end
   endtask

   task automatic store_then_load();
      logic [15:0] addr;
      repeat (4) begin
         addr = even_addr();
         access("store_then_load", {5'b10000, 11'($urandom)}, addr, 16'($urandom), 1'b0, 1'b0);
         access("store_then_load", {5'b10001, 11'($urandom)}, addr, 16'($urandom), 1'b1, 1'b0);
         last_addr = addr;
      end
   endtask

   task automatic stall_freeze();
      // known state ahead, then a load and a store-update on top of it
      access("stall_freeze", {5'b01000, 11'h2a5}, 16'h1234, 16'h5678, 1'b0, 1'b0);
      access("stall_freeze", {5'b10001, 11'($urandom)}, last_addr, 16'($urandom), 1'b1, 1'b0);
      access("stall_freeze", {5'b10011, 11'($urandom)}, last_addr, 16'($urandom), 1'b1, 1'b0);
   endtask

   task automatic odd_address_error();
      logic [15:0] addr;
      addr = even_addr();
      access("odd_address_error", {5'b10000, 11'($urandom)}, addr, 16'($urandom), 1'b0, 1'b0);
      // odd store flags err and leaves the even neighbour alone
      access("odd_address_error", {5'b10000, 11'($urandom)}, addr | 16'd1,
             16'($urandom), 1'b0, 1'b0);
      access("odd_address_error", {5'b10001, 11'($urandom)}, addr, 16'($urandom), 1'b1, 1'b0);
      access("odd_address_error", {5'b10001, 11'($urandom)}, addr | 16'd1,
             16'($urandom), 1'b1, 1'b0);
      // misalignment from execute on its own
      access("odd_address_error", {5'b01000, 11'($urandom)}, 16'($urandom),
             16'($urandom), 1'b1, 1'b1);
   endtask

   // xm_rd is combinational, checked before the instruction retires
   task automatic dest_case(input logic [15:0] ins, input logic [2:0] exp);
      drive(ins, 16'h0040, 16'($urandom), 1'b1, 1'b0);
      #1;
      check_eq("dest_decode_table", "xm_rd", 16'(exp), 16'(xm_rd));
      finish_access("dest_decode_table");
   endtask

   task automatic dest_decode_table();
      // stu first, so the ld after it reads a written word
      dest_case({5'b10011, 3'd4, 8'h25}, 3'd4);
      dest_case({5'b10001, 3'd2, 3'd5, 5'd3}, 3'd5);
      dest_case({5'b11000, 3'd6, 8'ha5}, 3'd6);
      dest_case({5'b11011, 3'd1, 3'd2, 3'd3, 2'b00}, 3'd3);
      dest_case({5'b00110, 11'h155}, 3'd7);
      dest_case({5'b01000, 3'd1, 3'd6, 5'd9}, 3'd6);
   endtask

   //////////////////////////////////////////////////////////////////////
   // sequence and watchdog
   //////////////////////////////////////////////////////////////////////
   initial begin
      instr      = '0;
      pc_inc     = '0;
      b_in       = '0;
      alu_res    = '0;
      rt_data    = '0;
      reg_wr     = 1'b0;
      align_err  = 1'b0;
      last_addr  = '0;
      void'($urandom(32'h1bab3d1a));
      wait (rst_n === 1'b1);
      @(posedge clk);
      #1;
      reset_check();
      passthrough();
      store_then_load();
      stall_freeze();
      odd_address_error();
      dest_decode_table();
      $display("=== PASS ===");
      $finish;
   end

   // watchdog, 40 cycles per test
   initial begin
      #(NUM_TESTS * 40 * CLK_PERIOD);
      stop_failed("timeout, the tests did not finish in time");
   end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
//////////////////////////////////////////////////////////////////////
// testbench clock and reset source
// free-running clock, rst_n low for a fixed number of cycles and
// released just after a rising edge
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 16
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // release 1 ns after the edge, same as the other inputs
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

//--- mem_top.sv
//////////////////////////////////////////////////////////////////////
// memory stage subsystem top level
// joins the stage, the stalling data memory and the destination
// decoder; everything outside is plain ports
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_config.svh"

module mem_top (
   input  logic               clk,
   input  logic               rst_n,
   input  logic [`DATA_W-1:0] instr,
   input  logic [`DATA_W-1:0] pc_inc,
   input  logic [`DATA_W-1:0] b_in,
   input  logic [`DATA_W-1:0] alu_res,
   input  logic [`DATA_W-1:0] rt_data,
   input  logic               reg_wr,
   input  logic               align_err,
   output logic [`DATA_W-1:0] instr_out,
   output logic [`DATA_W-1:0] pc_inc_out,
   output logic [`DATA_W-1:0] b_out,
   output logic [`DATA_W-1:0] alu_out,
   output logic [`DATA_W-1:0] rdata_out,
   output logic               reg_wr_out,
   output logic               err_out,
   output logic [2:0]         xm_rd,
   output logic               mem_stall
);

   // stage to memory access path
   dmem_if dmem_bus (.clk(clk));

   mem_stage i_stage (
      .clk        (clk),
      .rst_n      (rst_n),
      .instr      (instr),
      .pc_inc     (pc_inc),
      .b_in       (b_in),
      .alu_res    (alu_res),
      .rt_data    (rt_data),
      .reg_wr     (reg_wr),
      .align_err  (align_err),
      .dmem       (dmem_bus.stage),
      .instr_out  (instr_out),
      .pc_inc_out (pc_inc_out),
      .b_out      (b_out),
      .alu_out    (alu_out),
      .rdata_out  (rdata_out),
      .reg_wr_out (reg_wr_out),
      .err_out    (err_out),
      .mem_stall  (mem_stall)
   );

   stall_dmem i_dmem (
      .clk   (clk),
      .rst_n (rst_n),
      .dmem  (dmem_bus.mem)
   );

   // decoded off the incoming word, zero latency
   dest_decode i_dest (
      .instr (instr),
      .dest  (xm_rd)
   );

endmodule

`default_nettype wire

//--- mem_stage.sv
//////////////////////////////////////////////////////////////////////
// memory stage of the 5-stage pipeline
// decodes ld / st / stu, issues the data memory request and holds
// the x/m to m/w pipeline registers frozen while memory stalls
// mem_stall goes back to earlier stages as the only back-pressure
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_config.svh"

module mem_stage (
   input  logic               clk,
   input  logic               rst_n,
   input  logic [`DATA_W-1:0] instr,
   input  logic [`DATA_W-1:0] pc_inc,
   input  logic [`DATA_W-1:0] b_in,
   input  logic [`DATA_W-1:0] alu_res,
   input  logic [`DATA_W-1:0] rt_data,
   input  logic               reg_wr,
   input  logic               align_err,
   dmem_if.stage              dmem,
   output logic [`DATA_W-1:0] instr_out,
   output logic [`DATA_W-1:0] pc_inc_out,
   output logic [`DATA_W-1:0] b_out,
   output logic [`DATA_W-1:0] alu_out,
   output logic [`DATA_W-1:0] rdata_out,
   output logic               reg_wr_out,
   output logic               err_out,
   output logic               mem_stall
);

   logic [4:0] opcode;

   assign opcode = instr[`DATA_W-1 -: 5];

   //////////////////////////////////////////////////////////////////////
   // request generation
   //////////////////////////////////////////////////////////////////////

   // stores, plain and update form
   assign dmem.wr = (opcode == mem_pkg::OP_ST) || (opcode == mem_pkg::OP_STU);
   assign dmem.rd = (opcode == mem_pkg::OP_LD);

   // address from execute, store data always rt
   assign dmem.addr  = alu_res;
   assign dmem.wdata = rt_data;

   assign mem_stall = dmem.stall;

   //////////////////////////////////////////////////////////////////////
   // pipeline registers, load whenever memory is not stalling
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         instr_out  <= '0;
         pc_inc_out <= '0;
         b_out      <= '0;
         alu_out    <= '0;
         rdata_out  <= '0;
         reg_wr_out <= 1'b0;
         err_out    <= 1'b0;
      end else if (!dmem.stall) begin
         instr_out  <= instr;
         pc_inc_out <= pc_inc;
         b_out      <= b_in;
         alu_out    <= alu_res;
         rdata_out  <= dmem.rdata;
         reg_wr_out <= reg_wr;
         // misalignment from execute or odd address seen by memory
         err_out    <= align_err | dmem.err;
      end
   end

endmodule

`default_nettype wire

//--- dest_decode.sv
//////////////////////////////////////////////////////////////////////
// write-back destination register decoder
// purely combinational, feeds the hazard logic in the same cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module dest_decode (
   input  mem_pkg::instr_u instr,
   output logic [2:0]      dest
);

   logic [4:0] opcode;

   assign opcode = instr.i_form.opcode;

   // priority order matters, lbi also starts with 11
   always_comb begin
      if ((opcode == mem_pkg::OP_LBI) || (opcode == mem_pkg::OP_SLBI) ||
          (opcode == mem_pkg::OP_STU)) begin
         // immediate loads and store-update write rs
         dest = instr.r_form.rs;
      end else if (opcode[4:3] == 2'b11) begin
         // r-format alu ops
         dest = instr.r_form.rd;
      end else if (opcode[4:1] == 4'b0011) begin
         // jal / jalr link into r7
         dest = 3'd7;
      end else begin
         // i-format default
         dest = instr.i_form.rd;
      end
   end

endmodule

`default_nettype wire

//--- stall_dmem.sv
//////////////////////////////////////////////////////////////////////
// word-addressed data memory with a fixed multi-cycle access
// stall is high from the request up to the cycle before done,
// done pulses once with the read word, writes land on done
// odd byte addresses flag err with done and do not write
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_config.svh"

module stall_dmem (
   input logic   clk,
   input logic   rst_n,
   dmem_if.mem   dmem
);

   // word index width, the byte address drops bit 0
   localparam int AW = $clog2(`DMEM_WORDS);
   // counter only has to reach latency-1
   localparam int CNT_W = (`DMEM_LATENCY > 2) ? $clog2(`DMEM_LATENCY) : 1;
   localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`DMEM_LATENCY - 1);

   logic [`DATA_W-1:0] mem [`DMEM_WORDS];

   logic             busy;
   logic [CNT_W-1:0] cnt;
   logic             start;
   logic             last;
   logic [AW-1:0]    idx;

   assign idx = dmem.addr[AW:1];

   // new access only while idle
   assign start = !busy && (dmem.rd || dmem.wr);

   // final cycle of the access
   // single-cycle memory finishes in the request cycle
   assign last = (`DMEM_LATENCY == 1) ? start : (busy && (cnt == LAST_CNT));

   assign dmem.done  = last;
   assign dmem.stall = (start || busy) && !last;
   assign dmem.err   = last && dmem.addr[0];
   assign dmem.rdata = (last && dmem.rd) ? mem[idx] : '0;

   //////////////////////////////////////////////////////////////////////
   // access sequencing
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy <= 1'b0;
         cnt  <= '0;
      end else if (start && !last) begin
         // request cycle counts as cycle 0
         busy <= 1'b1;
         cnt  <= CNT_W'(1);
      end else if (busy) begin
         if (last) begin
            busy <= 1'b0;
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   // write in the done cycle, even addresses only
   always_ff @(posedge clk) begin
      if (last && dmem.wr && !dmem.addr[0]) begin
         mem[idx] <= dmem.wdata;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////////////////////////

   // one done per access, back-to-back only possible at latency 1
   a_done_pulse : assert property (@(posedge clk) disable iff (!rst_n)
      ((`DMEM_LATENCY > 1) && dmem.done) |=> !dmem.done);

   // upstream holds its request while the access runs
   a_addr_hold : assert property (@(posedge clk) disable iff (!rst_n)
      busy |-> $stable(dmem.addr));

endmodule

`default_nettype wire

//--- dmem_if.sv
//////////////////////////////////////////////////////////////////////
// access path between the memory stage and the data memory
// stage side drives the request, memory side answers with
// read data, done pulse, stall level and the odd-address error
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_config.svh"

interface dmem_if (
   input logic clk
);

   // request, from the stage
   logic [`DATA_W-1:0] addr;
   logic [`DATA_W-1:0] wdata;
   logic               rd;
   logic               wr;

   // response, from the memory
   logic [`DATA_W-1:0] rdata;
   logic               done;
   logic               stall;
   logic               err;

   modport stage (input clk, output addr, wdata, rd, wr, input rdata, done, stall, err);
   modport mem   (input clk, input addr, wdata, rd, wr, output rdata, done, stall, err);

endinterface

`default_nettype wire

//--- mem_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared types of the memory stage
// opcode constants and the two views of an instruction word,
// referenced by scoped name from the stage and the dest decoder
//////////////////////////////////////////////////////////////////////
`default_nettype none

package mem_pkg;

   // memory opcodes, bits 15..11 of the instruction
   localparam logic [4:0] OP_ST   = 5'b10000;
   localparam logic [4:0] OP_LD   = 5'b10001;
   localparam logic [4:0] OP_STU  = 5'b10011;

   // immediate loads, these write the register in bits 10..8
   localparam logic [4:0] OP_LBI  = 5'b11000;
   localparam logic [4:0] OP_SLBI = 5'b10010;

   // i-format: opcode, rs, rd, 5-bit immediate
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [4:0] imm;
   } i_form_t;

   // r-format: opcode, rs, rt, rd, 2-bit function
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] func;
   } r_form_t;

   // one word, decoded either way
   typedef union packed {
      i_form_t i_form;
      r_form_t r_form;
   } instr_u;

endpackage

`default_nettype wire

//--- mem_stage_config.svh
//////////////////////////////////////////////////////////////////////
// sizing of the memory stage and its data memory
// include wherever word width, memory depth or access latency is
// needed; the package holds the types and opcodes
//////////////////////////////////////////////////////////////////////
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// data, address and instruction word width
`define DATA_W 16

// data memory depth in 16-bit words
// byte address bits 8..1 select the word
`define DMEM_WORDS 256

// cycles from request to done, 1 means no stall at all
`define DMEM_LATENCY 4

`endif
